//--- ldpc_alu.f
+incdir+.
ldpc_alu_pkg.sv
int_alu.sv
ldpc_unit.sv
alu_result_sel.sv
ldpc_alu_top.sv
tb_clk_gen.sv
ldpc_alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the LDPC ALU testbench with Verilator and run it.
# The run passes only if the log holds the pass message.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f ldpc_alu.f --top-module ldpc_alu_tb -o ldpc_alu_sim

./obj_dir/ldpc_alu_sim | tee sim.log

if grep -q "Regression passed" sim.log; then
  echo "Simulation PASSED"
else
  echo "Simulation FAILED"
  exit 1
fi

//--- ldpc_alu_tb.sv
/*
 * Testbench for the LDPC-extended functional unit.
 * Drives issues on the falling edge with LFSR operands and directed
 * corners, keeps a reference model of the last issue and checks result,
 * branch flag and valid timing with concurrent assertions.
 */
`timescale 1ns/1ps
`include "ldpc_alu_settings.svh"

module ldpc_alu_tb import ldpc_alu_pkg::*; ();

  localparam int          N_RAND      = 8;
  localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;
  localparam int          NUM_ISSUES  = 8 * N_RAND + (5 * N_RAND + 2) + (6 * N_RAND + 6)
                                        + (4 * N_RAND + 9) + (3 * N_RAND + 8) + 4;
  localparam int          TIMEOUT_CYC = NUM_ISSUES + 50;

  logic             clk;
  logic             rst_n;
  logic             issue;
  fu_data_t         fu_data;
  logic [`XLEN-1:0] result;
  logic             branch_res;
  logic             valid;

  // Reference state, one issue behind the stimulus
  logic             exp_valid;
  logic [`XLEN-1:0] exp_result;
  logic             exp_branch;
  alu_op_e          exp_op;

  logic [31:0]      lfsr_state  = 32'd6;
  int               cycle_count = 0;

  tb_clk_gen i_clk_gen (
    .clk_o    (clk),
    .arst_n_o (rst_n)
  );

  ldpc_alu_top i_dut (
    .clk_i        (clk),
    .arst_n_i     (rst_n),
    .issue_i      (issue),
    .fu_data_i    (fu_data),
    .result_o     (result),
    .branch_res_o (branch_res),
    .valid_o      (valid)
  );

  // --------------------------------------------------
  // Random source
  // --------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
      nxt = nxt ^ LFSR_TAPS;
    end
    return nxt;
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value[i]   = lfsr_state[0];
    end
  endtask

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic logic [31:0] llr_word(input int v);
    logic [7:0] lane;
    lane = 8'(v);
    return {24'h0, lane};
  endfunction

  function automatic int clamp_llr(input int v);
    if (v > `LLR_SAT) begin
      return `LLR_SAT;
    end
    if (v < -`LLR_SAT) begin
      return -`LLR_SAT;
    end
    return v;
  endfunction

  function automatic logic [31:0] ref_result(input fu_data_t d);
    logic [31:0] a;
    logic [31:0] b;
    int          sh;
    int          la;
    int          lb;
    int          li;
    int          hi;
    logic [31:0] res;
    a  = d.operand_a;
    b  = d.operand_b;
    sh = int'(b[4:0]);
    la = int'($signed(a[7:0]));
    lb = int'($signed(b[7:0]));
    li = int'($signed(d.imm[7:0]));
    hi = (la > lb) ? la : lb;
    case (d.operator)
      ADD:              res = a + b;
      SUB:              res = a - b;
      ANDL:             res = a & b;
      ORL:              res = a | b;
      XORL:             res = a ^ b;
      ANDN:             res = a & ~b;
      ORN:              res = a | ~b;
      XNOR:             res = ~(a ^ b);
      SLL:              res = a << sh;
      SRL:              res = a >> sh;
      SRA:              res = 32'($signed(a) >>> sh);
      SLTS:             res = {31'b0, $signed(a) < $signed(b)};
      SLTU:             res = {31'b0, a < b};
      LDPC_MIN:         res = llr_word((la < lb) ? la : lb);
      LDPC_ABS:         res = llr_word((la < 0) ? -la : la);
      LDPC_ADD_SAT:     res = llr_word(clamp_llr(la + lb));
      LDPC_SUB_SAT:     res = llr_word(clamp_llr(la - lb));
      LDPC_MINMAX:      res = llr_word((li < hi) ? li : hi);
      LDPC_MIN_SORTING: res = llr_word((la != lb) ? la : li);
      LDPC_RSIGN_NMESS: res = llr_word((b[0] != (la >= 0)) ? li : -li);
      // Branch compares return no data
      default:          res = '0;
    endcase
    return res;
  endfunction

  function automatic logic ref_branch(input fu_data_t d);
    logic [31:0] a;
    logic [31:0] b;
    a = d.operand_a;
    b = d.operand_b;
    case (d.operator)
      EQ:  return a == b;
      NE:  return a != b;
      LTS: return $signed(a) < $signed(b);
      LTU: return a < b;
      GES: return $signed(a) >= $signed(b);
      GEU: return a >= b;
      LDPC_MIN, LDPC_ABS, LDPC_ADD_SAT, LDPC_SUB_SAT,
      LDPC_MINMAX, LDPC_MIN_SORTING, LDPC_RSIGN_NMESS: return 1'b0;
      default: return 1'b1;
    endcase
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_valid  <= 1'b0;
      exp_result <= '0;
      exp_branch <= 1'b0;
      exp_op     <= ADD;
    end else begin
      exp_valid <= issue;
      if (issue) begin
        exp_result <= ref_result(fu_data);
        exp_branch <= ref_branch(fu_data);
        exp_op     <= fu_data.operator;
      end
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  function automatic string check_label(input alu_op_e op, input string field);
    return {op.name(), " ", field};
  endfunction

  task automatic report_mismatch(input string test, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("[ERROR] %s expected %h actual %h", test, expected, actual);
    $display("Regression failed");
    $fatal(1, "Stopped at first mismatch");
  endtask

  // Reference registers reset with the DUT, so these also cover reset
  a_valid: assert property (@(posedge clk) valid == exp_valid)
    else report_mismatch("valid_timing", 32'($sampled(exp_valid)), 32'($sampled(valid)));

  a_result: assert property (@(posedge clk) result == exp_result)
    else report_mismatch(check_label($sampled(exp_op), "result"),
                         $sampled(exp_result), $sampled(result));

  a_branch: assert property (@(posedge clk) branch_res == exp_branch)
    else report_mismatch(check_label($sampled(exp_op), "branch"),
                         32'($sampled(exp_branch)), 32'($sampled(branch_res)));

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYC) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Regression failed");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic issue_op(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] c);
    @(negedge clk);
    issue             = 1'b1;
    fu_data.operator  = op;
    fu_data.operand_a = a;
    fu_data.operand_b = b;
    fu_data.imm       = c;
  endtask

  task automatic issue_random(input alu_op_e op);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    draw_bits(32, a);
    draw_bits(32, b);
    draw_bits(32, c);
    issue_op(op, a, b, c);
  endtask

  // Operand b equals operand a
  task automatic issue_equal(input alu_op_e op);
    logic [31:0] a;
    logic [31:0] c;
    draw_bits(32, a);
    draw_bits(32, c);
    issue_op(op, a, a, c);
  endtask

  task automatic go_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      issue = 1'b0;
    end
  endtask

  initial begin
    issue   = 1'b0;
    fu_data = '0;
    // Reset falls at 1 ns and rises again on a falling clock edge
    @(negedge rst_n);
    @(posedge rst_n);
    go_idle(2);

    // Integer arithmetic and logic
    for (int r = 0; r < N_RAND; r++) begin
      issue_random(ADD);
      issue_random(SUB);
      issue_random(ANDL);
      issue_random(ORL);
      issue_random(XORL);
      issue_random(ANDN);
      issue_random(ORN);
      issue_random(XNOR);
    end
    go_idle(1);

    // Shifts and set-less-than
    for (int r = 0; r < N_RAND; r++) begin
      issue_random(SLL);
      issue_random(SRL);
      issue_random(SRA);
      issue_random(SLTS);
      issue_random(SLTU);
    end
    // Signed and unsigned order disagree here
    issue_op(SLTS, 32'h8000_0000, 32'h0000_0001, 32'h0);
    issue_op(SLTU, 32'h8000_0000, 32'h0000_0001, 32'h0);
    go_idle(1);

    // Branch resolve
    for (int r = 0; r < N_RAND; r++) begin
      issue_random(EQ);
      issue_random(NE);
      issue_random(LTS);
      issue_random(LTU);
      issue_random(GES);
      issue_random(GEU);
    end
    issue_equal(EQ);
    issue_equal(NE);
    issue_equal(LTS);
    issue_equal(LTU);
    issue_equal(GES);
    issue_equal(GEU);
    go_idle(1);

    // LLR min, abs and saturation
    for (int r = 0; r < N_RAND; r++) begin
      issue_random(LDPC_MIN);
      issue_random(LDPC_ABS);
      issue_random(LDPC_ADD_SAT);
      issue_random(LDPC_SUB_SAT);
    end
    issue_op(LDPC_ADD_SAT, 32'h0000_007f, 32'h0000_007f, 32'h0);
    issue_op(LDPC_ADD_SAT, 32'hffff_ff80, 32'hffff_ff80, 32'h0);
    issue_op(LDPC_ADD_SAT, 32'h0000_0064, 32'h0000_001b, 32'h0);
    issue_op(LDPC_ADD_SAT, 32'hffff_ff9c, 32'hffff_ffe5, 32'h0);
    issue_op(LDPC_SUB_SAT, 32'h0000_007f, 32'hffff_ff80, 32'h0);
    issue_op(LDPC_SUB_SAT, 32'hffff_ff80, 32'h0000_007f, 32'h0);
    issue_op(LDPC_ABS, 32'hffff_ff80, 32'h0, 32'h0);
    issue_op(LDPC_ABS, 32'h1234_567f, 32'h0, 32'h0);
    issue_op(LDPC_MIN, 32'hffff_ff80, 32'h0000_007f, 32'h0);
    go_idle(1);

    // Three-operand LLR ops
    for (int r = 0; r < N_RAND; r++) begin
      issue_random(LDPC_MINMAX);
      issue_random(LDPC_MIN_SORTING);
      issue_random(LDPC_RSIGN_NMESS);
    end
    repeat (4) issue_equal(LDPC_MIN_SORTING);
    // Both signs of a against both values of b bit 0
    issue_op(LDPC_RSIGN_NMESS, 32'h0000_0035, 32'h0000_0000, 32'h0000_0021);
    issue_op(LDPC_RSIGN_NMESS, 32'h0000_0035, 32'h0000_0001, 32'h0000_0021);
    issue_op(LDPC_RSIGN_NMESS, 32'h0000_00c5, 32'h0000_0000, 32'h0000_0021);
    issue_op(LDPC_RSIGN_NMESS, 32'h0000_00c5, 32'h0000_0001, 32'h0000_0021);
    go_idle(1);

    // Isolated issues with idle gaps
    repeat (4) begin
      issue_random(ADD);
      go_idle(2);
    end

    go_idle(3);
    $display("Regression passed");
    $finish;
  end

endmodule

//--- tb_clk_gen.sv
/*
 * Clock and reset source for the LDPC ALU testbench.
 * 40 ns clock; the active-low reset is held for five clock cycles and
 * released on a falling edge, away from the sampling edge.
 */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  localparam int HALF_PERIOD_NS = 20;
  localparam int RESET_CYCLES   = 5;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD_NS clk_o = ~clk_o;
  end

  // Short high phase at start gives the asynchronous reset a falling edge
  initial begin
    arst_n_o = 1'b1;
    #1;
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

//--- ldpc_alu_top.sv
/*
 * Top level of the LDPC-extended functional unit.
 * Both combinational datapaths see the issue bundle directly; the
 * result stage registers the selected output one cycle after issue_i.
 */
`timescale 1ns/1ps
`include "ldpc_alu_settings.svh"

module ldpc_alu_top import ldpc_alu_pkg::*; (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             issue_i,
  input  fu_data_t         fu_data_i,
  output logic [`XLEN-1:0] result_o,
  output logic             branch_res_o,
  output logic             valid_o
);

  unit_res_t int_res;
  unit_res_t ldpc_res;

  // Integer and LLR datapaths in parallel
  int_alu i_int_alu (
    .fu_data_i (fu_data_i),
    .res_o     (int_res)
  );

  ldpc_unit i_ldpc_unit (
    .fu_data_i (fu_data_i),
    .res_o     (ldpc_res)
  );

  // Registered result
  alu_result_sel i_result_sel (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .issue_i      (issue_i),
    .op_i         (fu_data_i.operator),
    .int_res_i    (int_res),
    .ldpc_res_i   (ldpc_res),
    .result_o     (result_o),
    .branch_res_o (branch_res_o),
    .valid_o      (valid_o)
  );

endmodule

//--- alu_result_sel.sv
/*
 * Result stage of the LDPC-extended functional unit.
 * Picks the LDPC or integer result by operator class and registers
 * result and branch flag when issue_i is high. valid_o pulses for
 * the single cycle after each issue; results hold until the next one.
 */
`timescale 1ns/1ps
`include "ldpc_alu_settings.svh"

module alu_result_sel import ldpc_alu_pkg::*; (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             issue_i,
  input  alu_op_e          op_i,
  input  unit_res_t        int_res_i,
  input  unit_res_t        ldpc_res_i,
  output logic [`XLEN-1:0] result_o,
  output logic             branch_res_o,
  output logic             valid_o
);

  logic      is_ldpc;
  unit_res_t sel_res;

  // Operator class decode
  always_comb begin
    case (op_i)
      LDPC_MIN, LDPC_ABS,
      LDPC_ADD_SAT, LDPC_SUB_SAT,
      LDPC_MINMAX, LDPC_MIN_SORTING,
      LDPC_RSIGN_NMESS: is_ldpc = 1'b1;
      default:          is_ldpc = 1'b0;
    endcase
  end

  assign sel_res = is_ldpc ? ldpc_res_i : int_res_i;

  // --------------------------------------------------
  // Output registers
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o      <= 1'b0;
      result_o     <= '0;
      branch_res_o <= 1'b0;
    end else begin
      valid_o <= issue_i;
      if (issue_i) begin
        result_o     <= sel_res.result;
        branch_res_o <= sel_res.branch;
      end
    end
  end

endmodule

//--- ldpc_unit.sv
/*
 * LLR datapath of the LDPC-extended functional unit.
 * Bits 7:0 of operand_a, operand_b and imm are read as signed LLRs.
 * Purely combinational; the 8-bit result is zero-extended to the word
 * and the branch flag is always clear.
 */
`timescale 1ns/1ps
`include "ldpc_alu_settings.svh"

module ldpc_unit import ldpc_alu_pkg::*; (
  input  fu_data_t  fu_data_i,
  output unit_res_t res_o
);

  localparam logic signed [`LLR_W:0] SAT_POS = `LLR_SAT;
  localparam logic signed [`LLR_W:0] SAT_NEG = -`LLR_SAT;

  logic signed [`LLR_W-1:0] llr_a;
  logic signed [`LLR_W-1:0] llr_b;
  logic signed [`LLR_W-1:0] llr_imm;

  logic signed [`LLR_W:0]   sum_ext;
  logic signed [`LLR_W:0]   diff_ext;

  logic                     a_ge_b;
  logic [`LLR_W-1:0]        min_ab;
  logic [`LLR_W-1:0]        max_ab;
  logic [`LLR_W-1:0]        abs_a;
  logic [`LLR_W-1:0]        minmax_res;
  logic [`LLR_W-1:0]        sort_res;
  logic                     rsign_keep;
  logic [`LLR_W-1:0]        rsign_res;
  logic [`LLR_W-1:0]        llr_res;

  // Clamp a 9-bit sum to +/-LLR_SAT
  function automatic logic [`LLR_W-1:0] sat_llr(input logic signed [`LLR_W:0] val);
    logic [`LLR_W:0] clamped;
    if (val > SAT_POS) begin
      clamped = SAT_POS;
    end else if (val < SAT_NEG) begin
      clamped = SAT_NEG;
    end else begin
      clamped = val;
    end
    return clamped[`LLR_W-1:0];
  endfunction

  assign llr_a   = fu_data_i.operand_a[`LLR_W-1:0];
  assign llr_b   = fu_data_i.operand_b[`LLR_W-1:0];
  assign llr_imm = fu_data_i.imm[`LLR_W-1:0];

  // --------------------------------------------------
  // Two-operand ops
  // --------------------------------------------------
  // One guard bit so the sum never wraps before clamping
  assign sum_ext  = {llr_a[`LLR_W-1], llr_a} + {llr_b[`LLR_W-1], llr_b};
  assign diff_ext = {llr_a[`LLR_W-1], llr_a} - {llr_b[`LLR_W-1], llr_b};

  assign a_ge_b = (llr_a >= llr_b);
  assign min_ab = a_ge_b ? llr_b : llr_a;
  assign max_ab = a_ge_b ? llr_a : llr_b;

  // -128 has no positive twin and comes back unchanged
  assign abs_a = llr_a[`LLR_W-1] ? -llr_a : llr_a;

  // --------------------------------------------------
  // Three-operand ops
  // --------------------------------------------------
  assign minmax_res = ($signed(llr_imm) >= $signed(max_ab)) ? max_ab : llr_imm;

  // Keep a when it differs from b, otherwise fall back to imm
  assign sort_res = (llr_a != llr_b) ? llr_a : llr_imm;

  // Sign restore of the outgoing message
  assign rsign_keep = fu_data_i.operand_b[0] ^ ~llr_a[`LLR_W-1];
  assign rsign_res  = rsign_keep ? llr_imm : -llr_imm;

  always_comb begin
    case (fu_data_i.operator)
      LDPC_MIN:         llr_res = min_ab;
      LDPC_ABS:         llr_res = abs_a;
      LDPC_ADD_SAT:     llr_res = sat_llr(sum_ext);
      LDPC_SUB_SAT:     llr_res = sat_llr(diff_ext);
      LDPC_MINMAX:      llr_res = minmax_res;
      LDPC_MIN_SORTING: llr_res = sort_res;
      LDPC_RSIGN_NMESS: llr_res = rsign_res;
      default:          llr_res = '0;
    endcase
  end

  assign res_o = '{result: {{(`XLEN-`LLR_W){1'b0}}, llr_res}, branch: 1'b0};

endmodule

//--- int_alu.sv
/*
 * Integer datapath of the LDPC-extended functional unit.
 * Purely combinational: one adder with an optionally inverted operand b,
 * a single arithmetic right shifter reused for left shifts by bit
 * reversal, and one signed/unsigned comparator that serves both SLT
 * and branch resolution. Returns result word and branch flag.
 */
`timescale 1ns/1ps
`include "ldpc_alu_settings.svh"

module int_alu import ldpc_alu_pkg::*; (
  input  fu_data_t  fu_data_i,
  output unit_res_t res_o
);

  localparam int SHAMT_W = $clog2(`XLEN);

  logic [`XLEN-1:0]   operand_a_rev;

  // Adder
  logic               adder_op_b_negate;
  logic [`XLEN:0]     adder_in_a;
  logic [`XLEN:0]     operand_b_neg;
  logic [`XLEN:0]     adder_sum;
  logic [`XLEN-1:0]   adder_result;
  logic               adder_z_flag;

  // Shifter
  logic               shift_left;
  logic               shift_arithmetic;
  logic [SHAMT_W-1:0] shift_amt;
  logic [`XLEN-1:0]   shift_op_a;
  logic [`XLEN:0]     shift_op_a_ext;
  logic [`XLEN:0]     shift_right_result;
  logic [`XLEN-1:0]   shift_left_result;
  logic [`XLEN-1:0]   shift_result;

  // Comparator and outputs
  logic               cmp_signed;
  logic               less;
  logic               branch_res;
  logic [`XLEN-1:0]   int_result;

  // Bit reversal in front of and behind the right shifter
  genvar k;
  generate
    for (k = 0; k < `XLEN; k++) begin : g_rev
      assign operand_a_rev[k]     = fu_data_i.operand_a[`XLEN-1-k];
      assign shift_left_result[k] = shift_right_result[`XLEN-1-k];
    end
  endgenerate

  // --------------------------------------------------
  // Adder
  // --------------------------------------------------
  always_comb begin
    case (fu_data_i.operator)
      SUB, EQ, NE,
      ANDN, ORN, XNOR: adder_op_b_negate = 1'b1;
      default:         adder_op_b_negate = 1'b0;
    endcase
  end

  // Extra LSB carries the +1 of the two's complement into the sum
  assign adder_in_a    = {fu_data_i.operand_a, 1'b1};
  assign operand_b_neg = {fu_data_i.operand_b, 1'b0} ^ {(`XLEN+1){adder_op_b_negate}};
  assign adder_sum     = adder_in_a + operand_b_neg;
  assign adder_result  = adder_sum[`XLEN:1];
  assign adder_z_flag  = ~|adder_result;

  // --------------------------------------------------
  // Shifter
  // --------------------------------------------------
  assign shift_left       = (fu_data_i.operator == SLL);
  assign shift_arithmetic = (fu_data_i.operator == SRA);
  assign shift_amt        = fu_data_i.operand_b[SHAMT_W-1:0];

  assign shift_op_a     = shift_left ? operand_a_rev : fu_data_i.operand_a;
  assign shift_op_a_ext = {shift_arithmetic & shift_op_a[`XLEN-1], shift_op_a};

  // Sign bit is only set for SRA, so SRL and SLL fill with zeros
  assign shift_right_result = $unsigned($signed(shift_op_a_ext) >>> shift_amt);

  assign shift_result = shift_left ? shift_left_result : shift_right_result[`XLEN-1:0];

  // --------------------------------------------------
  // Comparator
  // --------------------------------------------------
  assign cmp_signed = fu_data_i.operator inside {SLTS, LTS, GES};

  assign less = $signed({cmp_signed & fu_data_i.operand_a[`XLEN-1], fu_data_i.operand_a}) <
                $signed({cmp_signed & fu_data_i.operand_b[`XLEN-1], fu_data_i.operand_b});

  // Branch resolve, non-branch ops report taken
  always_comb begin
    case (fu_data_i.operator)
      EQ:       branch_res = adder_z_flag;
      NE:       branch_res = ~adder_z_flag;
      LTS, LTU: branch_res = less;
      GES, GEU: branch_res = ~less;
      default:  branch_res = 1'b1;
    endcase
  end

  // --------------------------------------------------
  // Result mux
  // --------------------------------------------------
  always_comb begin
    case (fu_data_i.operator)
      ADD, SUB:      int_result = adder_result;
      ANDL, ANDN:    int_result = fu_data_i.operand_a & operand_b_neg[`XLEN:1];
      ORL, ORN:      int_result = fu_data_i.operand_a | operand_b_neg[`XLEN:1];
      XORL, XNOR:    int_result = fu_data_i.operand_a ^ operand_b_neg[`XLEN:1];
      SLL, SRL, SRA: int_result = shift_result;
      SLTS, SLTU:    int_result = {{(`XLEN-1){1'b0}}, less};
      // Branch compares and LDPC ops leave the word at zero
      default:       int_result = '0;
    endcase
  end

  assign res_o = '{result: int_result, branch: branch_res};

endmodule

//--- ldpc_alu_pkg.sv
/*
 * Types shared by the LDPC-extended functional unit and its testbench.
 * Holds the operator encoding, the issue bundle that enters both
 * datapaths and the result bundle that each datapath hands back.
 * Import with a wildcard in the module header.
 */
`include "ldpc_alu_settings.svh"

package ldpc_alu_pkg;

  // --------------------------------------------------
  // Operator encoding
  // --------------------------------------------------
  typedef enum logic [4:0] {
    // Integer group
    ADD, SUB,
    ANDL, ORL, XORL,
    ANDN, ORN, XNOR,
    SLL, SRL, SRA,
    SLTS, SLTU,
    // Branch compares
    EQ, NE, LTS, LTU, GES, GEU,
    // LDPC group, 8-bit LLR lanes
    LDPC_MIN,
    LDPC_ABS,
    LDPC_ADD_SAT,
    LDPC_SUB_SAT,
    LDPC_MINMAX,
    LDPC_MIN_SORTING,
    LDPC_RSIGN_NMESS
  } alu_op_e;

  // --------------------------------------------------
  // Issue bundle
  // --------------------------------------------------
  typedef struct packed {
    alu_op_e          operator;
    logic [`XLEN-1:0] operand_a;
    logic [`XLEN-1:0] operand_b;
    logic [`XLEN-1:0] imm;   // third source, LDPC ops only
  } fu_data_t;

  // Result returned by each datapath
  typedef struct packed {
    logic [`XLEN-1:0] result;
    logic             branch;
  } unit_res_t;

endpackage

//--- ldpc_alu_settings.svh
/*
 * Global sizing of the LDPC-extended functional unit.
 * Data word width, LLR lane width and the LLR saturation bound.
 * Included by the package, the RTL and the testbench model.
 */
`ifndef LDPC_ALU_SETTINGS_SVH
`define LDPC_ALU_SETTINGS_SVH

// Integer data word
`define XLEN 32

// One signed log-likelihood ratio
`define LLR_W 8

// Largest LLR magnitude kept after add/sub
`define LLR_SAT 127

`endif
